//--- src/zx_ports_pkg.sv
package zx_ports_pkg;

	//////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////

	typedef logic [7:0]  byte_t;     // data bus byte, register value
	typedef logic [15:0] addr_t;     // full z80 i/o address
	typedef logic [7:0]  loaddr_t;   // low address byte, used for decode
	typedef logic [5:0]  border_t;   // border colour out
	typedef logic [5:0]  page_t;     // 1 MB page number
	typedef logic [1:0]  chan_idx_t; // soundrive channel

	localparam int N_DAC = 4;

	//////////////////////////////////////////////////
	// port addresses, low byte only
	//////////////////////////////////////////////////

	localparam loaddr_t PORT_FE     = 8'hFE; // ula: border, beeper, keyboard
	localparam loaddr_t PORT_FD     = 8'hFD; // #7FFD paging and AY
	localparam loaddr_t PORT_F7     = 8'hF7; // #EFF7 pentagon 1 MB
	localparam loaddr_t PORT_KJOY   = 8'h1F; // kempston joystick
	localparam loaddr_t PORT_KMOUSE = 8'hDF; // kempston mouse
	localparam loaddr_t PORT_COVOX1 = 8'hFB;
	localparam loaddr_t PORT_COVOX2 = 8'hDD;

	// soundrive channels
	localparam loaddr_t PORT_SD0 = 8'h0F;
	localparam loaddr_t PORT_SD1 = 8'h1F; // shares the joystick address
	localparam loaddr_t PORT_SD2 = 8'h4F;
	localparam loaddr_t PORT_SD3 = 8'h5F;

	//////////////////////////////////////////////////
	// register fields
	//////////////////////////////////////////////////

	// #7FFD
	localparam int P7_LOCK_BIT = 5; // 48k lock
	localparam int P7_ROM_BIT  = 4;

	// #EFF7
	localparam int E7_BLOCK1M_BIT = 2; // 1 = 1 MB paging off, lock enabled
	localparam int E7_RAM0_BIT    = 3; // ram page 0 at #0000

	// #FE
	localparam int FE_BEEP_BIT     = 4;
	localparam int FE_TAPE_OUT_BIT = 3;

	//////////////////////////////////////////////////
	// write strobes, one zclk each
	//////////////////////////////////////////////////

	typedef struct packed {
		logic      fe;       // #FE
		logic      p7ffd;    // #FD with a15 low
		logic      eff7;     // #F7 with a12 low, not shadow
		logic      covox;    // #FB or #DD
		logic      sdrv;     // any soundrive port, not shadow
		chan_idx_t sdrv_idx; // which soundrive port
		logic      spare;    // tied low
	} port_wr_t;

endpackage

//--- src/io_strobe.sv
`timescale 1ns/1ps

module io_strobe (
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic iowr_now;
	logic iord_now;
	logic iowr_prev; // bus state seen on the previous edge
	logic iord_prev;

	assign iowr_now = ~(iorq_n | wr_n);
	assign iord_now = ~(iorq_n | rd_n);

	// pulse on the first edge a cycle is seen active
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_prev <= 1'b0;
			iord_prev <= 1'b0;
			port_wr   <= 1'b0;
			port_rd   <= 1'b0;
		end
		else
		begin
			iowr_prev <= iowr_now;
			iord_prev <= iord_now;
			port_wr   <= iowr_now & ~iowr_prev;
			port_rd   <= iord_now & ~iord_prev;
		end
	end

endmodule

//--- src/port_decode.sv
`timescale 1ns/1ps

module port_decode
	import zx_ports_pkg::*;
(
	input  addr_t    a,
	input  logic     dos,
	input  logic     iorq_n,
	input  logic     rd_n,
	input  logic     wr_n,
	input  logic     port_wr,
	output logic     porthit,
	output logic     external_port,
	output logic     ay_bc1,
	output logic     ay_bdir,
	output port_wr_t wr_stb
);

	loaddr_t   loa;
	logic      shadow;
	logic      sd_port;  // one of the four soundrive addresses
	chan_idx_t sd_idx;
	logic      pre_bc1;
	logic      pre_bdir;

	assign loa    = a[7:0];
	assign shadow = dos; // no #BF port, so dos alone

	//////////////////////////////////////////////////
	// hit and external flags
	//////////////////////////////////////////////////

	always_comb
	begin
		case (loa)
			PORT_FE, PORT_FD, PORT_KMOUSE, PORT_COVOX1, PORT_COVOX2:
				porthit = 1'b1;
			// #1F is joystick on read and soundrive 1 on write
			PORT_KJOY, PORT_F7, PORT_SD0, PORT_SD2, PORT_SD3:
				porthit = ~shadow;
			default:
				porthit = 1'b0;
		endcase
	end

	// #FFFD is served by the AY itself
	assign external_port = (loa == PORT_FD) && (a[15:14] == 2'b11);

	//////////////////////////////////////////////////
	// soundrive index
	//////////////////////////////////////////////////

	always_comb
	begin
		sd_port = 1'b1;
		sd_idx  = 2'd0;
		case (loa)
			PORT_SD0:
				sd_idx = 2'd0;
			PORT_SD1:
				sd_idx = 2'd1;
			PORT_SD2:
				sd_idx = 2'd2;
			PORT_SD3:
				sd_idx = 2'd3;
			default:
				sd_port = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// write strobes
	//////////////////////////////////////////////////

	assign wr_stb.fe       = port_wr && (loa == PORT_FE);
	assign wr_stb.p7ffd    = port_wr && (loa == PORT_FD) && !a[15];
	assign wr_stb.eff7     = port_wr && (loa == PORT_F7) && !a[12] && !shadow;
	assign wr_stb.covox    = port_wr && ((loa == PORT_COVOX1) || (loa == PORT_COVOX2));
	assign wr_stb.sdrv     = port_wr && sd_port && !shadow;
	assign wr_stb.sdrv_idx = sd_idx;
	assign wr_stb.spare    = 1'b0;

	//////////////////////////////////////////////////
	// AY select
	//////////////////////////////////////////////////

	// #FFFD address latch, #BFFD data
	always_comb
	begin
		pre_bc1  = 1'b0;
		pre_bdir = 1'b0;
		if (loa == PORT_FD)
		begin
			pre_bc1  = (a[15:14] == 2'b11);
			pre_bdir = a[15];
		end
	end

	assign ay_bc1  = pre_bc1 & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = pre_bdir & ~iorq_n & ~wr_n;

endmodule

//--- src/mem_paging.sv
`timescale 1ns/1ps

module mem_paging
	import zx_ports_pkg::*;
(
	input  logic     zclk,
	input  logic     rst_n,
	input  byte_t    din,
	input  port_wr_t wr_stb,
	output byte_t    p7ffd,
	output byte_t    peff7,
	output page_t    pent1m_page,
	output logic     pent1m_1m_on,
	output logic     pent1m_ram0_0,
	output logic     pent1m_rom
);

	byte_t p7ffd_raw;
	byte_t peff7_raw;
	logic  block1m;   // pentagon 1 MB mode off
	logic  block7ffd; // #7FFD write protect

	assign block1m   = peff7_raw[E7_BLOCK1M_BIT];
	assign block7ffd = p7ffd_raw[P7_LOCK_BIT] & block1m;

	//////////////////////////////////////////////////
	// #7FFD
	//////////////////////////////////////////////////

	// 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 high page
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_raw <= '0;
		else if (wr_stb.p7ffd && !block7ffd)
			p7ffd_raw <= din;
	end

	//////////////////////////////////////////////////
	// #EFF7
	//////////////////////////////////////////////////

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_raw <= '0;
		else if (wr_stb.eff7)
			peff7_raw <= din;
	end

	// high page bits hidden in 128k mode
	always_comb
	begin
		p7ffd = p7ffd_raw;
		peff7 = peff7_raw;
		if (block1m)
		begin
			p7ffd[7:5] = 3'b000;
			peff7[6]   = 1'b0;
			peff7[3:1] = 3'b000;
		end
	end

	//////////////////////////////////////////////////
	// pentagon 1 MB view, unmasked
	//////////////////////////////////////////////////

	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]};
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_raw[E7_RAM0_BIT];
	assign pent1m_rom    = p7ffd_raw[P7_ROM_BIT];

endmodule

//--- src/dac_channel.sv
`timescale 1ns/1ps

module dac_channel
	import zx_ports_pkg::*;
#(
	parameter chan_idx_t CHAN = 2'd0
)
(
	input  logic     zclk,
	input  logic     rst_n,
	input  byte_t    din,
	input  port_wr_t wr_stb,
	output byte_t    sample
);

	logic  beep;
	logic  tape;
	byte_t beep_pat; // level pattern for a #FE write

	assign beep = din[FE_BEEP_BIT];
	assign tape = din[FE_TAPE_OUT_BIT];

	always_comb
	begin
		case (CHAN)
			2'd0, 2'd1:
				beep_pat = {8{beep}};
			2'd2:
				beep_pat = {beep, {7{tape}}}; // beeper over tape
			default:
				beep_pat = {8{tape}};
		endcase
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			sample <= '0;
		else if (wr_stb.fe)
			sample <= beep_pat;
		else if (wr_stb.covox)
			sample <= din; // covox hits every channel
		else if (wr_stb.sdrv && (wr_stb.sdrv_idx == CHAN))
			sample <= din;
	end

endmodule

//--- src/ula_io.sv
`timescale 1ns/1ps

module ula_io
	import zx_ports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  byte_t      din,
	input  port_wr_t   wr_stb,
	input  addr_t      a,
	input  logic       dos,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       porthit,
	input  logic       external_port,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	input  logic [4:0] kj_in,
	input  byte_t      mus_in,
	output border_t    border,
	output byte_t      dout,
	output logic       dataout
);

	loaddr_t loa;

	assign loa = a[7:0];

	//////////////////////////////////////////////////
	// border
	//////////////////////////////////////////////////

	// 3-bit colour spread over the 6-bit output
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= '0;
		else if (wr_stb.fe)
			border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0};
	end

	//////////////////////////////////////////////////
	// read data
	//////////////////////////////////////////////////

	always_comb
	begin
		case (loa)
			PORT_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_KJOY:
			begin
				if (dos)
					dout = 8'hFF; // fdc space in shadow mode
				else
					dout = {3'b000, kj_in};
			end
			PORT_KMOUSE:
				dout = mus_in;
			default:
				dout = 8'hFF; // includes #F7
		endcase
	end

	// drive the z80 bus only for our own ports
	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

endmodule

//--- src/zx_ports.sv
`timescale 1ns/1ps

module zx_ports
	import zx_ports_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	input  addr_t      a,
	input  byte_t      din,
	input  logic       dos,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	input  logic [4:0] keys_in,
	input  logic       tape_read,
	input  logic [4:0] kj_in,
	input  byte_t      mus_in,
	output byte_t      dout,
	output logic       dataout,
	output logic       porthit,
	output logic       ay_bc1,
	output logic       ay_bdir,
	output border_t    border,
	output byte_t      psd [N_DAC],
	output byte_t      p7ffd,
	output byte_t      peff7,
	output page_t      pent1m_page,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0,
	output logic       pent1m_rom
);

	logic     port_wr;
	logic     external_port;
	port_wr_t wr_stb;

	// port_rd left open, only writes change state
	io_strobe u_io_strobe (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.port_wr (port_wr),
		.port_rd ()
	);

	port_decode u_port_decode (
		.a             (a),
		.dos           (dos),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.port_wr       (port_wr),
		.porthit       (porthit),
		.external_port (external_port),
		.ay_bc1        (ay_bc1),
		.ay_bdir       (ay_bdir),
		.wr_stb        (wr_stb)
	);

	mem_paging u_mem_paging (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.din           (din),
		.wr_stb        (wr_stb),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_page   (pent1m_page),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.pent1m_rom    (pent1m_rom)
	);

	ula_io u_ula_io (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.din           (din),
		.wr_stb        (wr_stb),
		.a             (a),
		.dos           (dos),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.porthit       (porthit),
		.external_port (external_port),
		.keys_in       (keys_in),
		.tape_read     (tape_read),
		.kj_in         (kj_in),
		.mus_in        (mus_in),
		.border        (border),
		.dout          (dout),
		.dataout       (dataout)
	);

	// covox / soundrive channels
	for (genvar i = 0; i < N_DAC; i++)
	begin : g_dac
		dac_channel #(
			.CHAN (chan_idx_t'(i))
		) u_dac_channel (
			.zclk   (zclk),
			.rst_n  (rst_n),
			.din    (din),
			.wr_stb (wr_stb),
			.sample (psd[i])
		);
	end

endmodule

//--- testbench/tb_zx_ports.sv
`timescale 1ns/1ps

module tb_zx_ports
	import zx_ports_pkg::*;
();

	// about 130 bus cycles of 6 clocks each, plus margin
	localparam int TIMEOUT_CYCLES = 4000;

	localparam byte_t SD_LO [4] = '{8'h0F, 8'h1F, 8'h4F, 8'h5F};
	localparam byte_t ALL_LO [10] = '{8'hFE, 8'hFD, 8'hDF, 8'hFB, 8'hDD,
		8'h1F, 8'hF7, 8'h0F, 8'h4F, 8'h5F};

	logic       zclk;
	logic       rst_n;
	addr_t      a;
	byte_t      din;
	logic       dos;
	logic       iorq_n;
	logic       rd_n;
	logic       wr_n;
	logic [4:0] keys_in;
	logic       tape_read;
	logic [4:0] kj_in;
	byte_t      mus_in;
	byte_t      dout;
	logic       dataout;
	logic       porthit;
	logic       ay_bc1;
	logic       ay_bdir;
	border_t    border;
	byte_t      psd [N_DAC];
	byte_t      p7ffd;
	byte_t      peff7;
	page_t      pent1m_page;
	logic       pent1m_1m_on;
	logic       pent1m_ram0_0;
	logic       pent1m_rom;

	// reference model state
	byte_t      m_p7ffd;
	byte_t      m_peff7;
	border_t    m_border;
	byte_t      m_psd [N_DAC];

	logic [31:0] rng;
	int          cycles;

	zx_ports u_zx_ports (.*);

	initial
	begin
		zclk = 1'b0;
		forever #2 zclk = ~zclk;
	end

	always @(posedge zclk)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the test did not finish", cycles);
			$display("sim failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic byte_t rand_byte();
		rng = xorshift32(rng);
		return rng[7:0];
	endfunction

	function automatic logic is_mapped(input byte_t lo);
		for (int i = 0; i < 10; i++)
			if (lo == ALL_LO[i])
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic logic exp_hit(input addr_t addr, input logic sh);
		case (addr[7:0])
			8'hFE, 8'hFD, 8'hDF, 8'hFB, 8'hDD:
				return 1'b1;
			8'h1F, 8'hF7, 8'h0F, 8'h4F, 8'h5F:
				return !sh;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic byte_t exp_dout(input addr_t addr);
		if (addr[7:0] == 8'hFE)
			return {1'b1, tape_read, 1'b0, keys_in};
		if (addr[7:0] == 8'h1F && !dos)
			return {3'b000, kj_in};
		if (addr[7:0] == 8'hDF)
			return mus_in;
		return 8'hFF;
	endfunction

	task automatic model_write(input addr_t addr, input byte_t d);
		byte_t lo;
		lo = addr[7:0];
		if (lo == 8'hFE)
		begin
			m_border = {d[1], 1'b0, d[2], 1'b0, d[0], 1'b0};
			m_psd[0] = {8{d[4]}};
			m_psd[1] = {8{d[4]}};
			m_psd[2] = {d[4], {7{d[3]}}};
			m_psd[3] = {8{d[3]}};
		end
		if (lo == 8'hFD && !addr[15] && !(m_p7ffd[5] && m_peff7[2]))
			m_p7ffd = d; // locked while both bits set
		if (lo == 8'hF7 && !addr[12] && !dos)
			m_peff7 = d;
		if (lo == 8'hFB || lo == 8'hDD)
			for (int i = 0; i < N_DAC; i++)
				m_psd[i] = d;
		for (int i = 0; i < N_DAC; i++)
			if (lo == SD_LO[i] && !dos)
				m_psd[i] = d;
	endtask

	task automatic expect_val(input string name, input byte_t exp, input byte_t act);
		assert (act === exp)
		else
		begin
			$display("ERR t=%0t %s expected %02h actual %02h", $time, name, exp, act);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic compare_state();
		byte_t exp_p7;
		byte_t exp_e7;
		exp_p7 = m_p7ffd;
		exp_e7 = m_peff7;
		if (m_peff7[2])
		begin
			exp_p7[7:5] = 3'b000;
			exp_e7      = exp_e7 & 8'hB1; // bits 6 and 3..1 hidden
		end
		@(negedge zclk);
		expect_val("border", m_border, border);
		for (int i = 0; i < N_DAC; i++)
			expect_val($sformatf("psd[%0d]", i), m_psd[i], psd[i]);
		expect_val("p7ffd", exp_p7, p7ffd);
		expect_val("peff7", exp_e7, peff7);
		expect_val("pent1m_page", {m_p7ffd[7:5], m_p7ffd[2:0]}, pent1m_page);
		expect_val("pent1m_1m_on", !m_peff7[2], pent1m_1m_on);
		expect_val("pent1m_ram0_0", m_peff7[3], pent1m_ram0_0);
		expect_val("pent1m_rom", m_p7ffd[4], pent1m_rom);
	endtask

	//////////////////////////////////////////////////
	// bus cycles
	//////////////////////////////////////////////////

	// 3 clocks active, 2 idle
	task automatic bus_cycle(input logic is_wr, input addr_t addr, input byte_t d);
		logic ext;
		logic hit;
		@(posedge zclk);
		rng       = xorshift32(rng);
		a         <= addr;
		din       <= d;
		iorq_n    <= 1'b0;
		wr_n      <= !is_wr;
		rd_n      <= is_wr;
		keys_in   <= rng[4:0];
		tape_read <= rng[5];
		kj_in     <= rng[12:8];
		mus_in    <= rng[23:16];
		repeat (2) @(posedge zclk);
		@(negedge zclk); // mid cycle, bus settled
		ext = (addr[7:0] == 8'hFD) && (addr[15:14] == 2'b11);
		hit = exp_hit(addr, dos);
		expect_val("porthit", hit, porthit);
		expect_val("ay_bc1", ext, ay_bc1);
		expect_val("ay_bdir", (addr[7:0] == 8'hFD) && addr[15] && is_wr, ay_bdir);
		if (is_wr)
			expect_val("dataout", 1'b0, dataout);
		else
		begin
			expect_val("dataout", hit && !ext, dataout);
			expect_val("dout", exp_dout(addr), dout);
		end
		@(posedge zclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		rd_n   <= 1'b1;
		@(posedge zclk);
		if (is_wr)
			model_write(addr, d);
		compare_state();
	endtask

	task automatic io_write(input addr_t addr, input byte_t d);
		bus_cycle(1'b1, addr, d);
	endtask

	task automatic io_read(input addr_t addr);
		bus_cycle(1'b0, addr, 8'h00);
	endtask

	task automatic set_shadow(input logic v);
		@(posedge zclk);
		dos <= v;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		addr_t ua;
		byte_t r;
		rng       = 32'hdb7f;
		cycles    = 0;
		rst_n     = 1'b0;
		a         = '0;
		din       = '0;
		dos       = 1'b0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		keys_in   = '0;
		tape_read = 1'b0;
		kj_in     = '0;
		mus_in    = '0;
		m_p7ffd   = '0;
		m_peff7   = '0;
		m_border  = '0;
		for (int i = 0; i < N_DAC; i++)
			m_psd[i] = '0;
		repeat (10) @(posedge zclk);
		rst_n <= 1'b1;
		compare_state();

		// ula port, border and beeper
		repeat (6)
			io_write(16'h00FE, rand_byte());
		repeat (4)
			io_read(16'hFFFE);

		// covox and soundrive
		io_write(16'h00FB, rand_byte());
		io_write(16'h00DD, rand_byte());
		for (int i = 0; i < 4; i++)
			io_write({8'h00, SD_LO[i]}, rand_byte());
		set_shadow(1'b1);
		for (int i = 0; i < 4; i++)
			io_write({8'h00, SD_LO[i]}, rand_byte());
		io_write(16'h00FB, rand_byte()); // covox still loads in shadow
		set_shadow(1'b0);

		// paging with 1 MB on
		repeat (4)
		begin
			io_write(16'h7FFD, rand_byte());
			io_write(16'hEFF7, rand_byte() & 8'hFB);
		end
		io_write(16'hFFFD, rand_byte()); // a15 set, not #7FFD
		io_write(16'hFFF7, rand_byte()); // a12 set, not #EFF7

		// lock, then unlock through block1m
		io_write(16'h7FFD, rand_byte() | 8'h20);
		io_write(16'hEFF7, rand_byte() | 8'h04);
		repeat (3)
			io_write(16'h7FFD, rand_byte());
		io_write(16'hEFF7, rand_byte() & 8'hFB);
		io_write(16'h7FFD, rand_byte());

		// AY register and data ports
		io_write(16'hFFFD, rand_byte());
		io_write(16'hBFFD, rand_byte());
		io_read(16'hFFFD);
		io_read(16'hBFFD);

		// joystick, mouse, #F7 and unmapped reads
		io_read(16'h001F);
		set_shadow(1'b1);
		io_read(16'h001F);
		io_read(16'h00F7);
		set_shadow(1'b0);
		io_read(16'hFFDF);
		io_read(16'h00F7);
		repeat (4)
		begin
			ua[15:8] = rand_byte();
			ua[7:0]  = rand_byte();
			while (is_mapped(ua[7:0]))
				ua[7:0] = rand_byte();
			io_read(ua);
		end

		// mixed traffic over all ports
		repeat (80)
		begin
			r        = rand_byte();
			ua[15:8] = rand_byte();
			ua[7:0]  = ALL_LO[r[3:0] % 10];
			if (r[4])
				io_write(ua, rand_byte());
			else
				io_read(ua);
			if (r[7:5] == 3'b000)
				set_shadow(!dos);
		end

		$display("sim passed");
		$finish;
	end

endmodule

//--- sim.f
src/zx_ports_pkg.sv
src/io_strobe.sv
src/port_decode.sv
src/mem_paging.sv
src/dac_channel.sv
src/ula_io.sv
src/zx_ports.sv
testbench/tb_zx_ports.sv
